// File: gb_macros.svh
`ifndef GB_MACROS_SVH
`define GB_MACROS_SVH

// bus widths
`define GB_ADR_W      16
`define GB_DATA_W     8
`define GB_VRAM_ADR_W 13
`define GB_OAM_ADR_W  8

// last address of the boot ROM overlay
`define GB_BOOTROM_END 16'h00FF

// memory map, upper bound of each region
`define GB_ROM_END  16'h7FFF
`define GB_VRAM_END 16'h9FFF
`define GB_XRAM_END 16'hBFFF
`define GB_WRAM_END 16'hFDFF   // includes echo ram
`define GB_OAM_END  16'hFE9F
`define GB_IO_BASE  16'hFF00

`define GB_INIT_TICKS 16       // power-on delay
`define GB_RST_TICKS  16       // length of assert and of release
`define GB_OPEN_BUS   8'hFF

`endif

// File: gb_pkg.sv
`default_nettype none
`include "gb_macros.svh"

package gb_pkg;

	typedef enum logic [2:0] {
		region_none,
		region_rom,
		region_vram,
		region_xram,
		region_wram,
		region_oam,
		region_io
	} mem_region_e;

	typedef enum logic [3:0] {
		io_none,
		io_joypad,
		io_serial,
		io_timer,
		io_int_flag,
		io_sound,
		io_ppu,
		io_brom_reg,
		io_hram,
		io_int_ena
	} io_sel_e;

	typedef enum logic [1:0] {
		rst_assert,
		rst_release,
		rst_done
	} rst_state_e;

	// ****************************************
	// bus bundles
	// ****************************************

	typedef struct packed {
		logic [`GB_ADR_W-1:0]  adr;
		logic                  rd;
		logic                  wr;
		logic [`GB_DATA_W-1:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic                     active;
		logic [`GB_ADR_W-1:0]     src_adr;
		logic [`GB_OAM_ADR_W-1:0] oam_adr;
		logic                     rd;
		logic                     wr;
		logic [`GB_DATA_W-1:0]    wdata;
	} dma_bus_t;

	typedef struct packed {
		logic                 need_vram;
		logic                 need_oam;
		logic [`GB_ADR_W-1:0] adr;
		logic                 rd;
	} ppu_req_t;

	typedef struct packed {
		logic [`GB_VRAM_ADR_W-1:0] adr;
		logic                      rd;
		logic                      wr;
		logic [`GB_DATA_W-1:0]     wdata;
	} vram_port_t;

	typedef struct packed {
		logic [`GB_OAM_ADR_W-1:0] adr;
		logic                     rd;
		logic                     wr;
		logic [`GB_DATA_W-1:0]    wdata;
	} oam_port_t;

	typedef struct packed {
		logic [`GB_ADR_W-1:0]  adr;
		logic                  rd;
		logic                  wr;
		logic [`GB_DATA_W-1:0] wdata;
		logic                  data_oe;
		logic                  cs_rom;
		logic                  cs_xram;
		logic                  cs_wram;
	} ext_port_t;

	typedef struct packed {
		logic [`GB_DATA_W-1:0] joy;
		logic [`GB_DATA_W-1:0] sio;
		logic [`GB_DATA_W-1:0] tim;
		logic [`GB_DATA_W-1:0] snd;
		logic [`GB_DATA_W-1:0] ppu;
		logic [`GB_DATA_W-1:0] cpureg;
		logic [`GB_DATA_W-1:0] hram;
		logic [`GB_DATA_W-1:0] brom;
	} periph_rdata_t;

	typedef struct packed {
		logic cpu_vram;
		logic cpu_oam;
		logic dma_vram;
	} vid_grant_t;

	// rom, cartridge ram and wram all live on the external bus
	function automatic logic is_ext_region(mem_region_e r);
		return r == region_rom || r == region_xram || r == region_wram;
	endfunction

endpackage

`default_nettype wire

// File: gb_reset_seq.sv
`default_nettype none
`include "gb_macros.svh"

module gb_reset_seq (
	input  logic gbclk,
	input  logic rst_n,
	input  logic gb_on,
	input  logic n_crst_in,
	output logic reset_gb,
	output logic n_crst_out
);
	import gb_pkg::*;

	localparam int init_w = $clog2(`GB_INIT_TICKS);
	localparam int tick_w = $clog2(`GB_RST_TICKS);
	localparam logic [init_w-1:0] init_last = init_w'(`GB_INIT_TICKS - 1);
	localparam logic [tick_w-1:0] tick_last = tick_w'(`GB_RST_TICKS - 1);

	logic              gb_on_q;
	logic [init_w-1:0] init_ticks;
	logic [init_w-1:0] init_ticks_d;
	logic              init_done;
	logic              init_done_d;
	rst_state_e        state;
	rst_state_e        state_d;
	logic [tick_w-1:0] ticks;
	logic [tick_w-1:0] ticks_d;

	// ****************************************
	// next state
	// ****************************************

	always_comb begin
		init_ticks_d = init_ticks;
		init_done_d  = init_done;
		state_d      = state;
		ticks_d      = ticks;

		if (!init_done) begin
			init_ticks_d = init_ticks + 1'b1;
			if (init_ticks == init_last)
				init_done_d = 1'b1;
		end

		if (init_done) begin
			case (state)
			rst_assert: begin
				if (ticks == tick_last) begin
					state_d = rst_release;
					ticks_d = '0;
				end else
					ticks_d = ticks + 1'b1;
			end
			rst_release: begin
				if (!n_crst_in)
					ticks_d = '0;   // cartridge still holds reset
				else if (ticks == tick_last)
					state_d = rst_done;
				else
					ticks_d = ticks + 1'b1;
			end
			default: begin
			end
			endcase
		end

		// power switch moved, or cartridge pulls its reset line
		if (gb_on_q != gb_on || (state == rst_done && !n_crst_in)) begin
			state_d = rst_assert;
			ticks_d = '0;
		end
	end

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			gb_on_q    <= 1'b0;
			init_ticks <= '0;
			init_done  <= 1'b0;
			state      <= rst_assert;
			ticks      <= '0;
		end else begin
			gb_on_q    <= gb_on;
			init_ticks <= init_ticks_d;
			init_done  <= init_done_d;
			state      <= state_d;
			ticks      <= ticks_d;
		end
	end

	assign reset_gb   = !(state == rst_done && gb_on);
	assign n_crst_out = init_done && gb_on && state != rst_assert;

endmodule

`default_nettype wire

// File: gb_memmap.sv
`default_nettype none
`include "gb_macros.svh"

module gb_memmap (
	input  logic [`GB_ADR_W-1:0] adr,
	output gb_pkg::mem_region_e  region
);
	import gb_pkg::*;

	always_comb begin
		if (adr <= `GB_ROM_END)
			region = region_rom;
		else if (adr <= `GB_VRAM_END)
			region = region_vram;
		else if (adr <= `GB_XRAM_END)
			region = region_xram;
		else if (adr <= `GB_WRAM_END)
			region = region_wram;   // echo area maps onto wram
		else if (adr <= `GB_OAM_END)
			region = region_oam;
		else if (adr >= `GB_IO_BASE)
			region = region_io;
		else
			region = region_none;   // fea0..feff unused
	end

endmodule

`default_nettype wire

// File: gb_ioregs.sv
`default_nettype none
`include "gb_macros.svh"

module gb_ioregs (
	input  logic                gbclk,
	input  logic                rst_n,
	input  gb_pkg::cpu_bus_t    cpu,
	input  gb_pkg::mem_region_e cpu_region,
	output gb_pkg::io_sel_e     io_sel,
	output logic                brom_sel,
	output logic                hide_bootrom
);
	import gb_pkg::*;

	// ff00 page, low byte only
	always_comb begin
		io_sel = io_none;
		if (cpu_region == region_io) begin
			case (cpu.adr[7:0]) inside
			8'h00:         io_sel = io_joypad;
			[8'h01:8'h02]: io_sel = io_serial;
			[8'h04:8'h07]: io_sel = io_timer;
			8'h0F:         io_sel = io_int_flag;
			[8'h10:8'h3F]: io_sel = io_sound;   // incl. wave ram
			[8'h40:8'h4B]: io_sel = io_ppu;
			8'h50:         io_sel = io_brom_reg;
			[8'h80:8'hFE]: io_sel = io_hram;
			8'hFF:         io_sel = io_int_ena;
			default:       io_sel = io_none;
			endcase
		end
	end

	// any nonzero write to ff50 unmaps the boot rom for good
	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n)
			hide_bootrom <= 1'b0;
		else if (cpu.wr && io_sel == io_brom_reg && cpu.wdata != '0)
			hide_bootrom <= 1'b1;
	end

	assign brom_sel = !hide_bootrom && cpu.adr <= `GB_BOOTROM_END;

endmodule

`default_nettype wire

// File: gb_vid_arbiter.sv
`default_nettype none
`include "gb_macros.svh"

module gb_vid_arbiter (
	input  gb_pkg::cpu_bus_t    cpu,
	input  gb_pkg::dma_bus_t    dma,
	input  gb_pkg::ppu_req_t    ppu,
	input  gb_pkg::mem_region_e cpu_region,
	input  gb_pkg::mem_region_e dma_region_raw,
	output gb_pkg::vram_port_t  vram,
	output gb_pkg::oam_port_t   oam,
	output gb_pkg::vid_grant_t  grant
);
	import gb_pkg::*;

	logic dma_vram;

	assign dma_vram = dma.active && dma_region_raw == region_vram;

	// ****************************************
	// vram: ppu, then dma source, then cpu
	// ****************************************

	always_comb begin
		vram           = '0;
		grant.dma_vram = 1'b0;
		grant.cpu_vram = 1'b0;

		if (ppu.need_vram) begin
			vram.adr = ppu.adr[`GB_VRAM_ADR_W-1:0];
			vram.rd  = ppu.rd;
		end else if (dma_vram) begin
			vram.adr       = dma.src_adr[`GB_VRAM_ADR_W-1:0];
			vram.rd        = dma.rd;
			grant.dma_vram = 1'b1;
		end else if (cpu_region == region_vram) begin
			vram.adr       = cpu.adr[`GB_VRAM_ADR_W-1:0];
			vram.rd        = cpu.rd;
			vram.wr        = cpu.wr;
			vram.wdata     = cpu.wdata;
			grant.cpu_vram = 1'b1;
		end
	end

	// ****************************************
	// oam: ppu, then dma target, then cpu
	// ****************************************

	always_comb begin
		oam           = '0;
		grant.cpu_oam = 1'b0;

		if (ppu.need_oam) begin
			oam.adr = ppu.adr[`GB_OAM_ADR_W-1:0];
			oam.rd  = ppu.rd;
		end else if (dma.active) begin
			oam.adr   = dma.oam_adr;   // cpu is locked out for the whole transfer
			oam.wr    = dma.wr;
			oam.wdata = dma.wdata;
		end else if (cpu_region == region_oam) begin
			oam.adr       = cpu.adr[`GB_OAM_ADR_W-1:0];
			oam.rd        = cpu.rd;
			oam.wr        = cpu.wr;
			oam.wdata     = cpu.wdata;
			grant.cpu_oam = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: gb_ext_bus.sv
`default_nettype none

module gb_ext_bus (
	input  logic                gbclk,
	input  logic                rst_n,
	input  gb_pkg::cpu_bus_t    cpu,
	input  gb_pkg::dma_bus_t    dma,
	input  gb_pkg::mem_region_e cpu_region,
	input  gb_pkg::mem_region_e dma_region_raw,
	output gb_pkg::ext_port_t   ext,
	output logic                cpu_ext_grant
);
	import gb_pkg::*;

	mem_region_e dma_region;
	logic        dma_own;
	logic        ext_wr;
	logic        wr_q;

	assign dma_region    = dma.active ? dma_region_raw : region_none;
	assign dma_own       = is_ext_region(dma_region);
	assign cpu_ext_grant = is_ext_region(cpu_region) && !dma_own;
	assign ext_wr        = dma_own ? 1'b0 : cpu.wr;   // dma only reads here

	// keep driving the data lines one cycle past the write
	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n)
			wr_q <= 1'b0;
		else
			wr_q <= ext_wr;
	end

	always_comb begin
		ext.adr     = dma_own ? dma.src_adr : cpu.adr;
		ext.rd      = dma_own ? dma.rd : cpu.rd;
		ext.wr      = ext_wr;
		ext.wdata   = cpu.wdata;
		ext.data_oe = ext_wr || wr_q;
		ext.cs_rom  = cpu_region == region_rom || dma_region == region_rom;
		ext.cs_xram = cpu_region == region_xram || dma_region == region_xram;
		ext.cs_wram = cpu_region == region_wram || dma_region == region_wram;
	end

endmodule

`default_nettype wire

// File: gb_rdata_mux.sv
`default_nettype none
`include "gb_macros.svh"

module gb_rdata_mux (
	input  gb_pkg::mem_region_e   cpu_region,
	input  gb_pkg::mem_region_e   dma_region_raw,
	input  logic                  dma_active,
	input  gb_pkg::io_sel_e       io_sel,
	input  logic                  brom_sel,
	input  gb_pkg::vid_grant_t    grant,
	input  logic                  cpu_ext_grant,
	input  gb_pkg::periph_rdata_t periph,
	input  logic [`GB_DATA_W-1:0] vram_rdata,
	input  logic [`GB_DATA_W-1:0] oam_rdata,
	input  logic [`GB_DATA_W-1:0] ext_rdata,
	output logic [`GB_DATA_W-1:0] cpu_rdata,
	output logic [`GB_DATA_W-1:0] dma_rdata
);
	import gb_pkg::*;

	logic                  io_hit;
	logic [`GB_DATA_W-1:0] io_rdata;

	assign io_hit = cpu_region == region_io && io_sel != io_none;

	always_comb begin
		case (io_sel)
		io_joypad:               io_rdata = periph.joy;
		io_serial:               io_rdata = periph.sio;
		io_timer:                io_rdata = periph.tim;
		io_sound:                io_rdata = periph.snd;
		io_ppu:                  io_rdata = periph.ppu;
		io_int_flag, io_int_ena: io_rdata = periph.cpureg;   // both live in the cpu
		io_hram:                 io_rdata = periph.hram;
		default:                 io_rdata = `GB_OPEN_BUS;
		endcase
	end

	// ****************************************
	// cpu side
	// ****************************************

	always_comb begin
		if (io_hit)
			cpu_rdata = io_rdata;
		else if (brom_sel)
			cpu_rdata = periph.brom;
		else if (grant.cpu_vram)
			cpu_rdata = vram_rdata;
		else if (grant.cpu_oam)
			cpu_rdata = oam_rdata;
		else if (cpu_ext_grant)
			cpu_rdata = ext_rdata;
		else
			cpu_rdata = `GB_OPEN_BUS;   // lost arbitration or unmapped
	end

	// dma side
	always_comb begin
		if (grant.dma_vram)
			dma_rdata = vram_rdata;
		else if (dma_active && is_ext_region(dma_region_raw))
			dma_rdata = ext_rdata;
		else
			dma_rdata = `GB_OPEN_BUS;
	end

endmodule

`default_nettype wire

// File: gb_sysbus.sv
`default_nettype none
`include "gb_macros.svh"

module gb_sysbus (
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  logic                  gb_on,
	input  logic                  n_crst_in,
	input  gb_pkg::cpu_bus_t      cpu,
	input  gb_pkg::dma_bus_t      dma,
	input  gb_pkg::ppu_req_t      ppu,
	input  gb_pkg::periph_rdata_t periph,
	input  logic [`GB_DATA_W-1:0] vram_rdata,
	input  logic [`GB_DATA_W-1:0] oam_rdata,
	input  logic [`GB_DATA_W-1:0] ext_rdata,
	output logic                  reset_gb,
	output logic                  n_crst_out,
	output gb_pkg::io_sel_e       io_sel,
	output gb_pkg::vram_port_t    vram,
	output gb_pkg::oam_port_t     oam,
	output gb_pkg::ext_port_t     ext,
	output logic [`GB_DATA_W-1:0] cpu_rdata,
	output logic [`GB_DATA_W-1:0] dma_rdata
);
	import gb_pkg::*;

	mem_region_e cpu_region;
	mem_region_e dma_region_raw;   // not yet qualified by dma.active
	logic        brom_sel;
	vid_grant_t  grant;
	logic        cpu_ext_grant;

	// ****************************************
	// reset and decode
	// ****************************************

	gb_reset_seq rst_seq (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.gb_on      (gb_on),
		.n_crst_in  (n_crst_in),
		.reset_gb   (reset_gb),
		.n_crst_out (n_crst_out)
	);

	gb_memmap cpu_map (
		.adr    (cpu.adr),
		.region (cpu_region)
	);

	gb_memmap dma_map (
		.adr    (dma.src_adr),
		.region (dma_region_raw)
	);

	gb_ioregs io_regs (
		.gbclk        (gbclk),
		.rst_n        (rst_n),
		.cpu          (cpu),
		.cpu_region   (cpu_region),
		.io_sel       (io_sel),
		.brom_sel     (brom_sel),
		.hide_bootrom ()
	);

	// ****************************************
	// ports and read data
	// ****************************************

	gb_vid_arbiter vid_arb (
		.cpu            (cpu),
		.dma            (dma),
		.ppu            (ppu),
		.cpu_region     (cpu_region),
		.dma_region_raw (dma_region_raw),
		.vram           (vram),
		.oam            (oam),
		.grant          (grant)
	);

	gb_ext_bus ext_if (
		.gbclk          (gbclk),
		.rst_n          (rst_n),
		.cpu            (cpu),
		.dma            (dma),
		.cpu_region     (cpu_region),
		.dma_region_raw (dma_region_raw),
		.ext            (ext),
		.cpu_ext_grant  (cpu_ext_grant)
	);

	gb_rdata_mux rd_mux (
		.cpu_region     (cpu_region),
		.dma_region_raw (dma_region_raw),
		.dma_active     (dma.active),
		.io_sel         (io_sel),
		.brom_sel       (brom_sel),
		.grant          (grant),
		.cpu_ext_grant  (cpu_ext_grant),
		.periph         (periph),
		.vram_rdata     (vram_rdata),
		.oam_rdata      (oam_rdata),
		.ext_rdata      (ext_rdata),
		.cpu_rdata      (cpu_rdata),
		.dma_rdata      (dma_rdata)
	);

endmodule

`default_nettype wire

// File: gb_sysbus_checker.sv
`default_nettype none
`include "gb_macros.svh"

module gb_sysbus_checker (
	input logic               gbclk,
	input logic               rst_n,
	input gb_pkg::dma_bus_t   dma,
	input gb_pkg::ext_port_t  ext,
	input gb_pkg::vid_grant_t grant,
	input logic               reset_gb,
	input logic               n_crst_out
);
	import gb_pkg::*;

	logic dma_owns_ext;

	// dma source in rom, cartridge ram or wram
	assign dma_owns_ext = dma.active && (dma.src_adr <= `GB_ROM_END ||
		(dma.src_adr > `GB_VRAM_END && dma.src_adr <= `GB_WRAM_END));

	no_wr_under_dma: assert property (@(posedge gbclk) disable iff (!rst_n)
		dma_owns_ext |-> !ext.wr) else $error("ext write while dma owns the bus");

	one_vram_grant: assert property (@(posedge gbclk) disable iff (!rst_n)
		!(grant.cpu_vram && grant.dma_vram)) else $error("two vram grants");

	oe_after_wr: assert property (@(posedge gbclk) disable iff (!rst_n)
		ext.wr |=> ext.data_oe) else $error("data_oe dropped right after a write");

	reset_with_crst: assert property (@(posedge gbclk) disable iff (!rst_n)
		!n_crst_out |-> reset_gb) else $error("reset_gb low while cartridge in reset");

endmodule

bind gb_sysbus gb_sysbus_checker chk0 (
	.gbclk      (gbclk),
	.rst_n      (rst_n),
	.dma        (dma),
	.ext        (ext),
	.grant      (grant),
	.reset_gb   (reset_gb),
	.n_crst_out (n_crst_out)
);

`default_nettype wire

// File: tb_gb_sysbus.sv
`default_nettype none
`include "gb_macros.svh"

module tb_gb_sysbus;
	import gb_pkg::*;

	localparam int timeout_cycles = 2000;   // ~200 reset cycles plus rows, big margin

	typedef struct {
		string      name;
		cpu_bus_t   cpu;
		dma_bus_t   dma;
		ppu_req_t   ppu;
		logic [7:0] exp_cpu;
		logic [7:0] exp_dma;
		logic [2:0] exp_cs;     // rom, xram, wram
		io_sel_e    exp_io;
		logic [1:0] exp_vram;   // rd, wr
		logic [1:0] exp_oam;
		logic [7:0] exp_oadr;
		logic       exp_dma_own;
		logic [12:0] exp_vadr;
	} row_t;

	logic          gbclk;
	logic          rst_n;
	logic          gb_on;
	logic          n_crst_in;
	cpu_bus_t      cpu;
	dma_bus_t      dma;
	ppu_req_t      ppu;
	periph_rdata_t periph;
	logic [7:0]    vram_rdata;
	logic [7:0]    oam_rdata;
	logic [7:0]    ext_rdata;
	logic          reset_gb;
	logic          n_crst_out;
	io_sel_e       io_sel;
	vram_port_t    vram;
	oam_port_t     oam;
	ext_port_t     ext;
	logic [7:0]    cpu_rdata;
	logic [7:0]    dma_rdata;
	row_t          rows[$];
	int            cycles = 0;

	gb_sysbus dut0 (.*);

	initial gbclk = 1'b0;
	always #10 gbclk = !gbclk;

	// ****************************************
	// reporting and compare tasks
	// ****************************************

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge gbclk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_io(string name, io_sel_e exp, io_sel_e act);
		if (act !== exp) begin
			$display("ERROR %s io_sel: expected %s actual %s", name, exp.name(), act.name());
			abort_run();
		end
	endtask

	task automatic check_ext(string name, ext_port_t exp, ext_port_t act);
		if ({act.adr, act.rd, act.wr, act.cs_rom, act.cs_xram, act.cs_wram} !==
		    {exp.adr, exp.rd, exp.wr, exp.cs_rom, exp.cs_xram, exp.cs_wram}) begin
			$display("ERROR %s ext: expected adr %h rd %b wr %b cs %b%b%b actual adr %h rd %b wr %b cs %b%b%b",
				name, exp.adr, exp.rd, exp.wr, exp.cs_rom, exp.cs_xram, exp.cs_wram,
				act.adr, act.rd, act.wr, act.cs_rom, act.cs_xram, act.cs_wram);
			abort_run();
		end
	endtask

	task automatic check_vram(string name, vram_port_t exp, vram_port_t act);
		if ({act.rd, act.wr} !== {exp.rd, exp.wr} ||
		    ((exp.rd || exp.wr) && act.adr !== exp.adr)) begin
			$display("ERROR %s vram: expected rd %b wr %b adr %h actual rd %b wr %b adr %h",
				name, exp.rd, exp.wr, exp.adr, act.rd, act.wr, act.adr);
			abort_run();
		end
	endtask

	task automatic check_oam(string name, oam_port_t exp, oam_port_t act);
		if ({act.rd, act.wr} !== {exp.rd, exp.wr} ||
		    ((exp.rd || exp.wr) && act.adr !== exp.adr)) begin
			$display("ERROR %s oam: expected rd %b wr %b adr %h actual rd %b wr %b adr %h",
				name, exp.rd, exp.wr, exp.adr, act.rd, act.wr, act.adr);
			abort_run();
		end
	endtask

	// ****************************************
	// stimulus helpers and table
	// ****************************************

	function automatic cpu_bus_t cpu_read(logic [15:0] a);
		cpu_bus_t c;
		c = '0;
		c.adr = a;
		c.rd  = 1'b1;
		return c;
	endfunction

	function automatic cpu_bus_t cpu_write(logic [15:0] a, logic [7:0] d);
		cpu_bus_t c;
		c = '0;
		c.adr   = a;
		c.wr    = 1'b1;
		c.wdata = d;
		return c;
	endfunction

	function automatic dma_bus_t dma_copy(logic [15:0] src, logic [7:0] oadr, logic [7:0] d);
		dma_bus_t m;
		m = '0;
		m.active  = 1'b1;
		m.src_adr = src;
		m.oam_adr = oadr;
		m.rd      = 1'b1;
		m.wr      = 1'b1;
		m.wdata   = d;
		return m;
	endfunction

	function automatic ppu_req_t ppu_fetch(logic v, logic o, logic [15:0] a);
		ppu_req_t p;
		p.need_vram = v;
		p.need_oam  = o;
		p.adr       = a;
		p.rd        = 1'b1;
		return p;
	endfunction

	task automatic add_row(string name, cpu_bus_t c, dma_bus_t d, ppu_req_t p,
		logic [7:0] ec, logic [7:0] ed, logic [2:0] cs, io_sel_e io,
		logic [1:0] v, logic [1:0] o, logic [7:0] oadr, logic own,
		logic [12:0] vadr = 13'h0000);
		row_t r;
		r = '{name, c, d, p, ec, ed, cs, io, v, o, oadr, own, vadr};
		rows.push_back(r);
	endtask

	task automatic build_table();
		dma_bus_t n;
		ppu_req_t q;
		n = '0;
		q = '0;
		add_row("brom_0000", cpu_read(16'h0000), n, q, 8'h88, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
		add_row("brom_00ff", cpu_read(16'h00FF), n, q, 8'h88, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
		add_row("rom_0100", cpu_read(16'h0100), n, q, 8'hC3, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
		add_row("rom_7fff", cpu_read(16'h7FFF), n, q, 8'hC3, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
		add_row("vram_8000", cpu_read(16'h8000), n, q, 8'hA1, 8'hFF, 3'b000, io_none, 2, 0, 0, 0,
			13'h0000);
		add_row("vram_9fff", cpu_read(16'h9FFF), n, q, 8'hA1, 8'hFF, 3'b000, io_none, 2, 0, 0, 0,
			13'h1FFF);
		add_row("xram_a000", cpu_read(16'hA000), n, q, 8'hC3, 8'hFF, 3'b010, io_none, 0, 0, 0, 0);
		add_row("xram_bfff", cpu_read(16'hBFFF), n, q, 8'hC3, 8'hFF, 3'b010, io_none, 0, 0, 0, 0);
		add_row("wram_c000", cpu_read(16'hC000), n, q, 8'hC3, 8'hFF, 3'b001, io_none, 0, 0, 0, 0);
		add_row("echo_e000", cpu_read(16'hE000), n, q, 8'hC3, 8'hFF, 3'b001, io_none, 0, 0, 0, 0);
		add_row("echo_fdff", cpu_read(16'hFDFF), n, q, 8'hC3, 8'hFF, 3'b001, io_none, 0, 0, 0, 0);
		add_row("oam_fe00", cpu_read(16'hFE00), n, q, 8'hB2, 8'hFF, 3'b000, io_none, 0, 2, 8'h00, 0);
		add_row("oam_fe9f", cpu_read(16'hFE9F), n, q, 8'hB2, 8'hFF, 3'b000, io_none, 0, 2, 8'h9F, 0);
		add_row("unused_fea0", cpu_read(16'hFEA0), n, q, 8'hFF, 8'hFF, 3'b000, io_none, 0, 0, 0, 0);
		add_row("unused_feff", cpu_read(16'hFEFF), n, q, 8'hFF, 8'hFF, 3'b000, io_none, 0, 0, 0, 0);
		add_row("io_ff00", cpu_read(16'hFF00), n, q, 8'h11, 8'hFF, 3'b000, io_joypad, 0, 0, 0, 0);
		add_row("io_ff01", cpu_read(16'hFF01), n, q, 8'h22, 8'hFF, 3'b000, io_serial, 0, 0, 0, 0);
		add_row("io_ff02", cpu_read(16'hFF02), n, q, 8'h22, 8'hFF, 3'b000, io_serial, 0, 0, 0, 0);
		add_row("io_ff03", cpu_read(16'hFF03), n, q, 8'hFF, 8'hFF, 3'b000, io_none, 0, 0, 0, 0);
		add_row("io_ff04", cpu_read(16'hFF04), n, q, 8'h33, 8'hFF, 3'b000, io_timer, 0, 0, 0, 0);
		add_row("io_ff07", cpu_read(16'hFF07), n, q, 8'h33, 8'hFF, 3'b000, io_timer, 0, 0, 0, 0);
		add_row("io_ff08", cpu_read(16'hFF08), n, q, 8'hFF, 8'hFF, 3'b000, io_none, 0, 0, 0, 0);
		add_row("io_ff0f", cpu_read(16'hFF0F), n, q, 8'h66, 8'hFF, 3'b000, io_int_flag, 0, 0, 0, 0);
		add_row("io_ff10", cpu_read(16'hFF10), n, q, 8'h44, 8'hFF, 3'b000, io_sound, 0, 0, 0, 0);
		add_row("io_ff3f", cpu_read(16'hFF3F), n, q, 8'h44, 8'hFF, 3'b000, io_sound, 0, 0, 0, 0);
		add_row("io_ff40", cpu_read(16'hFF40), n, q, 8'h55, 8'hFF, 3'b000, io_ppu, 0, 0, 0, 0);
		add_row("io_ff4b", cpu_read(16'hFF4B), n, q, 8'h55, 8'hFF, 3'b000, io_ppu, 0, 0, 0, 0);
		add_row("io_ff4c", cpu_read(16'hFF4C), n, q, 8'hFF, 8'hFF, 3'b000, io_none, 0, 0, 0, 0);
		add_row("io_ff50", cpu_read(16'hFF50), n, q, 8'hFF, 8'hFF, 3'b000, io_brom_reg, 0, 0, 0, 0);
		add_row("io_ff80", cpu_read(16'hFF80), n, q, 8'h77, 8'hFF, 3'b000, io_hram, 0, 0, 0, 0);
		add_row("io_fffe", cpu_read(16'hFFFE), n, q, 8'h77, 8'hFF, 3'b000, io_hram, 0, 0, 0, 0);
		add_row("io_ffff", cpu_read(16'hFFFF), n, q, 8'h66, 8'hFF, 3'b000, io_int_ena, 0, 0, 0, 0);
		// boot rom hide latch
		add_row("brom_wr_zero", cpu_write(16'hFF50, 8'h00), n, q,
			8'hFF, 8'hFF, 3'b000, io_brom_reg, 0, 0, 0, 0);
		add_row("brom_still", cpu_read(16'h0050), n, q, 8'h88, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
		add_row("brom_hide", cpu_write(16'hFF50, 8'h01), n, q,
			8'hFF, 8'hFF, 3'b000, io_brom_reg, 0, 0, 0, 0);
		add_row("brom_hidden", cpu_read(16'h0050), n, q, 8'hC3, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
		// video arbitration and external ownership
		add_row("ppu_takes_vram", cpu_read(16'h8010), n, ppu_fetch(1, 0, 16'h8123),
			8'hFF, 8'hFF, 3'b000, io_none, 2, 0, 0, 0, 13'h0123);
		add_row("ppu_takes_oam", cpu_read(16'hFE10), n, ppu_fetch(0, 1, 16'hFE20),
			8'hFF, 8'hFF, 3'b000, io_none, 0, 2, 8'h20, 0);
		add_row("dma_oam_write", cpu_read(16'hFE10), dma_copy(16'hC000, 8'h05, 8'h5A), q,
			8'hFF, 8'hC3, 3'b001, io_none, 0, 1, 8'h05, 1);
		add_row("dma_vram_src", cpu_read(16'h0150), dma_copy(16'h8100, 8'h06, 8'h5B), q,
			8'hC3, 8'hA1, 3'b100, io_none, 2, 1, 8'h06, 0, 13'h0100);
		add_row("dma_rom_cpu_wr", cpu_write(16'hC010, 8'h99), dma_copy(16'h1234, 8'h07, 8'h5C), q,
			8'hFF, 8'hC3, 3'b101, io_none, 0, 1, 8'h07, 1);
		add_row("cpu_vram_idle", cpu_write(16'h8200, 8'h12), n, q,
			8'hA1, 8'hFF, 3'b000, io_none, 1, 0, 0, 0, 13'h0200);
		add_row("cpu_oam_idle", cpu_write(16'hFE30, 8'h34), n, q,
			8'hB2, 8'hFF, 3'b000, io_none, 0, 1, 8'h30, 0);
		add_row("dma_off_rom", cpu_read(16'h4000), n, q, 8'hC3, 8'hFF, 3'b100, io_none, 0, 0, 0, 0);
	endtask

	task automatic apply_row(row_t r);
		ext_port_t  e;
		vram_port_t v;
		oam_port_t  o;
		e = '0;
		v = '0;
		o = '0;
		@(posedge gbclk);
		cpu <= r.cpu;
		dma <= r.dma;
		ppu <= r.ppu;
		@(negedge gbclk);
		// the dma keeps the external bus read-only
		e.adr     = r.exp_dma_own ? r.dma.src_adr : r.cpu.adr;
		e.rd      = r.exp_dma_own ? r.dma.rd : r.cpu.rd;
		e.wr      = r.exp_dma_own ? 1'b0 : r.cpu.wr;
		{e.cs_rom, e.cs_xram, e.cs_wram} = r.exp_cs;
		{v.rd, v.wr} = r.exp_vram;
		v.adr = r.exp_vadr;
		{o.rd, o.wr} = r.exp_oam;
		o.adr = r.exp_oadr;
		check_byte({r.name, " cpu_rdata"}, r.exp_cpu, cpu_rdata);
		check_byte({r.name, " dma_rdata"}, r.exp_dma, dma_rdata);
		check_io(r.name, r.exp_io, io_sel);
		check_ext(r.name, e, ext);
		check_vram(r.name, v, vram);
		check_oam(r.name, o, oam);
	endtask

	// count falling edges until reset_gb reaches the wanted level
	task automatic wait_reset_level(logic level, int limit, output int n);
		n = 0;
		do begin
			@(negedge gbclk);
			n++;
			if (n > limit) begin
				$display("reset_gb never reached %b within %0d cycles", level, limit);
				abort_run();
			end
		end while (reset_gb !== level);
	endtask

	// ****************************************
	// main sequence
	// ****************************************

	initial begin
		int n;
		rst_n      = 1'b0;
		gb_on      = 1'b1;
		n_crst_in  = 1'b1;
		cpu        = '0;
		dma        = '0;
		ppu        = '0;
		periph     = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77, 8'h88};
		vram_rdata = 8'hA1;
		oam_rdata  = 8'hB2;
		ext_rdata  = 8'hC3;

		repeat (8) @(posedge gbclk);
		rst_n <= 1'b1;
		@(negedge gbclk);
		check_bit("reset_gb after rst", 1'b1, reset_gb);
		check_bit("n_crst_out after rst", 1'b0, n_crst_out);
		check_bit("data_oe after rst", 1'b0, ext.data_oe);
		wait_reset_level(1'b0, 60, n);
		if (n < 48 || n > 52) begin
			$display("first release took %0d cycles, outside 48..52", n);
			abort_run();
		end
		check_bit("n_crst_out after release", 1'b1, n_crst_out);

		// cartridge pulls its reset line
		@(posedge gbclk);
		n_crst_in <= 1'b0;
		wait_reset_level(1'b1, 2, n);
		@(posedge gbclk);
		n_crst_in <= 1'b1;
		wait_reset_level(1'b0, 40, n);
		if (n < 32 || n > 36) begin
			$display("release after cartridge reset took %0d cycles, outside 32..36", n);
			abort_run();
		end

		// power switch off holds reset
		@(posedge gbclk);
		gb_on <= 1'b0;
		repeat (10) begin
			@(negedge gbclk);
			check_bit("reset_gb with gb_on low", 1'b1, reset_gb);
			check_bit("n_crst_out with gb_on low", 1'b0, n_crst_out);
		end
		@(posedge gbclk);
		gb_on <= 1'b1;
		wait_reset_level(1'b0, 40, n);

		build_table();
		foreach (rows[i])
			apply_row(rows[i]);

		// data_oe stretch on a wram write
		@(posedge gbclk);
		cpu <= cpu_write(16'hC000, 8'hAA);
		dma <= '0;
		ppu <= '0;
		@(negedge gbclk);
		check_bit("data_oe during write", 1'b1, ext.data_oe);
		@(posedge gbclk);
		cpu <= cpu_read(16'hC000);
		@(negedge gbclk);
		check_bit("data_oe one after write", 1'b1, ext.data_oe);
		@(posedge gbclk);
		@(negedge gbclk);
		check_bit("data_oe two after write", 1'b0, ext.data_oe);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: gb_sysbus.f
+incdir+.
gb_pkg.sv
gb_reset_seq.sv
gb_memmap.sv
gb_ioregs.sv
gb_vid_arbiter.sv
gb_ext_bus.sv
gb_rdata_mux.sv
gb_sysbus.sv
gb_sysbus_checker.sv
tb_gb_sysbus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gb_sysbus
DUT_TOP   ?= gb_sysbus
FLIST     ?= gb_sysbus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
